// File: source/rvga_defs.svh
`ifndef RVGA_DEFS_SVH
`define RVGA_DEFS_SVH

// Data path and address width.
`define RVGA_XLEN 32

// Data memory depth in words. Keep this a power of two.
`define RVGA_DMEM_WORDS 256

// Cycles from a data memory request to its response, at least 1.
`define RVGA_DMEM_LAT 2

`endif

// File: source/rvga_pkg.sv
`include "rvga_defs.svh"

package rvga_types;

  typedef logic [`RVGA_XLEN-1:0] rvga_word;

  // RV32I major opcodes.
  typedef enum logic [6:0] {
    OP_NOP    = 7'b0000000, // Bubble.
    OP_LOAD   = 7'b0000011,
    OP_OPIMM  = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_OP     = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111
  } rvga_opcode_e;

  // Load and store widths as encoded in funct3.
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } rvga_mem_f3_e;

  typedef enum logic {
    S_IDLE = 1'b0,
    S_WAIT = 1'b1 // Memory request outstanding.
  } rvga_mem_state_e;

  typedef struct packed {
    rvga_word     pc;
    rvga_opcode_e opcode;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [4:0]   rd;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         br_v;
    logic         rd_w_v;
    logic         imm_v;
    rvga_word     imm;
    rvga_word     rs1_data;
    rvga_word     rs2_data;
    rvga_word     alu_result; // Also the load or store address.
    rvga_word     br_tgt;
  } rvga_execute_cword;

  typedef struct packed {
    rvga_word     pc;
    rvga_opcode_e opcode;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [4:0]   rd;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         br_v;
    logic         rd_w_v;
    logic         imm_v;
    rvga_word     imm;
    rvga_word     rs1_data;
    rvga_word     rs2_data;
    rvga_word     alu_result;
    rvga_word     br_tgt;
    rvga_word     wb_data;
    logic         misalign_v;
  } rvga_memory_cword;

endpackage : rvga_types

// File: source/memory_ctl.sv
module memory_ctl import rvga_types::*;
  (input logic clk_i
   , input logic rst_n_i

   , input logic stall_v_i
   , input logic flush_v_i

   , input rvga_opcode_e opcode_i
   , input logic misalign_v_i

   , input logic dmem_resp_v_i
   , output logic dmem_r_v_o
   , output logic dmem_w_v_o

   , output logic mem_stall_o
   , output logic cword_w_v_o
   , output logic cmux_sel_o
   );

  rvga_mem_state_e state_r, state_n;
  logic flush_pend_r, flush_pend_n;
  logic load_v, store_v;

  // Misaligned accesses pass through without touching memory.
  assign load_v  = (opcode_i == OP_LOAD) & ~misalign_v_i;
  assign store_v = (opcode_i == OP_STORE) & ~misalign_v_i;

  assign mem_stall_o = (state_r == S_WAIT);

  always_comb begin
    state_n      = state_r;
    flush_pend_n = flush_pend_r;
    dmem_r_v_o   = 1'b0;
    dmem_w_v_o   = 1'b0;
    cword_w_v_o  = 1'b0;
    cmux_sel_o   = 1'b0;
    case (state_r)
      S_IDLE: begin
        if (flush_v_i) begin
          // Incoming word is killed before it can issue a request.
          cword_w_v_o = 1'b1;
          cmux_sel_o  = 1'b1;
        end else if (!stall_v_i) begin
          if (load_v | store_v) begin
            dmem_r_v_o = load_v;
            dmem_w_v_o = store_v;
            state_n    = S_WAIT;
          end else begin
            cword_w_v_o = 1'b1; // One cycle pass-through.
          end
        end
      end
      S_WAIT: begin
        if (dmem_resp_v_i) begin
          // The response is always captured, a flush only zeroes it.
          cword_w_v_o  = 1'b1;
          cmux_sel_o   = flush_v_i | flush_pend_r;
          flush_pend_n = 1'b0;
          state_n      = S_IDLE;
        end else if (flush_v_i) begin
          flush_pend_n = 1'b1; // Remembered until the response.
        end
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r      <= S_IDLE;
      flush_pend_r <= 1'b0;
    end else begin
      state_r      <= state_n;
      flush_pend_r <= flush_pend_n;
    end
  end

endmodule : memory_ctl

// File: source/memory_dp.sv
module memory_dp import rvga_types::*;
  (input logic clk_i
   , input logic rst_n_i

   , input rvga_execute_cword cword_i

   , input rvga_word dmem_data_i
   , output rvga_word dmem_addr_o
   , output rvga_word dmem_data_o
   , output logic [3:0] dmem_be_o

   , output logic misalign_v_o
   , output rvga_word load_data_o
   );

  rvga_word addr;
  rvga_mem_f3_e f3;
  logic mem_op;
  logic [1:0] off_r;
  rvga_mem_f3_e f3_r;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;

  assign addr   = cword_i.alu_result;
  assign f3     = rvga_mem_f3_e'(cword_i.funct3);
  assign mem_op = (cword_i.opcode == OP_LOAD) || (cword_i.opcode == OP_STORE);

  assign dmem_addr_o = addr & ~rvga_word'(3); // Word aligned.

  always_comb begin
    case (f3)
      F3_H, F3_HU: begin
        misalign_v_o = mem_op & addr[0];
      end
      F3_W: begin
        misalign_v_o = mem_op & (addr[1:0] != 2'b00);
      end
      default: begin
        misalign_v_o = 1'b0;
      end
    endcase
  end

  // Store data moves into the addressed lanes.
  always_comb begin
    case (f3)
      F3_B, F3_BU: begin
        dmem_be_o   = 4'b0001 << addr[1:0];
        dmem_data_o = rvga_word'(cword_i.rs2_data[7:0]) << {addr[1:0], 3'b000};
      end
      F3_H, F3_HU: begin
        dmem_be_o   = 4'b0011 << {addr[1], 1'b0};
        dmem_data_o = rvga_word'(cword_i.rs2_data[15:0]) << {addr[1], 4'b0000};
      end
      default: begin
        dmem_be_o   = 4'b1111;
        dmem_data_o = cword_i.rs2_data;
      end
    endcase
  end

  // The stage holds its source word during a wait,
  // so these still describe the request when the response comes.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      off_r <= 2'b00;
      f3_r  <= F3_W;
    end else begin
      off_r <= addr[1:0];
      f3_r  <= f3;
    end
  end

  assign byte_sel = dmem_data_i[{off_r, 3'b000} +: 8];
  assign half_sel = dmem_data_i[{off_r[1], 4'b0000} +: 16];

  always_comb begin
    case (f3_r)
      F3_B: begin
        load_data_o = {{24{byte_sel[7]}}, byte_sel};
      end
      F3_BU: begin
        load_data_o = {24'b0, byte_sel};
      end
      F3_H: begin
        load_data_o = {{16{half_sel[15]}}, half_sel};
      end
      F3_HU: begin
        load_data_o = {16'b0, half_sel};
      end
      default: begin
        load_data_o = dmem_data_i;
      end
    endcase
  end

endmodule : memory_dp

// File: source/memory_stage.sv
module memory_stage import rvga_types::*;
  (input logic clk_i
   , input logic rst_n_i

   , input logic stall_v_i
   , input logic flush_v_i

   , input rvga_execute_cword cword_i
   , output rvga_memory_cword cword_o

   , output logic dmem_r_v_o
   , output logic dmem_w_v_o
   , output rvga_word dmem_addr_o
   , output rvga_word dmem_data_o
   , output logic [3:0] dmem_be_o
   , input rvga_word dmem_data_i
   , input logic dmem_resp_v_i

   , output logic mem_stall_o
   , output logic br_v_o
   );

  logic cmux_sel;
  logic cword_w_v;
  logic misalign_v;
  rvga_word load_data;
  rvga_execute_cword hold_r, src;
  rvga_memory_cword cword_n, cword_r;

  memory_ctl ctl
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.stall_v_i(stall_v_i)
     ,.flush_v_i(flush_v_i)
     ,.opcode_i(src.opcode)
     ,.misalign_v_i(misalign_v)
     ,.dmem_resp_v_i(dmem_resp_v_i)
     ,.dmem_r_v_o(dmem_r_v_o)
     ,.dmem_w_v_o(dmem_w_v_o)
     ,.mem_stall_o(mem_stall_o)
     ,.cword_w_v_o(cword_w_v)
     ,.cmux_sel_o(cmux_sel)
     );

  memory_dp dp
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cword_i(src)
     ,.dmem_data_i(dmem_data_i)
     ,.dmem_addr_o(dmem_addr_o)
     ,.dmem_data_o(dmem_data_o)
     ,.dmem_be_o(dmem_be_o)
     ,.misalign_v_o(misalign_v)
     ,.load_data_o(load_data)
     );

  // Upstream moves on after the request, so the memory op is kept here.
  always_ff @(posedge clk_i) begin
    if (dmem_r_v_o | dmem_w_v_o) begin
      hold_r <= cword_i;
    end
  end

  assign src = mem_stall_o ? hold_r : cword_i;

  always_comb begin
    cword_n.pc         = src.pc;
    cword_n.opcode     = src.opcode;
    cword_n.rs1        = src.rs1;
    cword_n.rs2        = src.rs2;
    cword_n.rd         = src.rd;
    cword_n.funct3     = src.funct3;
    cword_n.funct7     = src.funct7;
    cword_n.br_v       = src.br_v;
    cword_n.rd_w_v     = src.rd_w_v;
    cword_n.imm_v      = src.imm_v;
    cword_n.imm        = src.imm;
    cword_n.rs1_data   = src.rs1_data;
    cword_n.rs2_data   = src.rs2_data;
    cword_n.alu_result = src.alu_result;
    cword_n.br_tgt     = src.br_tgt;
    cword_n.misalign_v = misalign_v;
    if (mem_stall_o && (src.opcode == OP_LOAD)) begin
      cword_n.wb_data = load_data;
    end else begin
      cword_n.wb_data = src.alu_result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cword_r <= '0;
    end else if (cword_w_v) begin
      cword_r <= cmux_sel ? rvga_memory_cword'('0) : cword_n; // Flush gives a bubble.
    end
  end

  assign cword_o = cword_r;
  assign br_v_o  = cword_r.br_v;

endmodule : memory_stage

// File: source/data_ram.sv
`include "rvga_defs.svh"

module data_ram import rvga_types::*;
  (input logic clk_i
   , input logic rst_n_i

   , input logic r_v_i
   , input logic w_v_i
   , input rvga_word addr_i
   , input rvga_word data_i
   , input logic [3:0] be_i

   , output rvga_word data_o
   , output logic resp_v_o
   );

  localparam int unsigned DEPTH = `RVGA_DMEM_WORDS;
  localparam int unsigned IDX_W = $clog2(DEPTH);
  localparam int unsigned LAT   = `RVGA_DMEM_LAT;
  localparam int unsigned CNT_W = $clog2(LAT + 1);

  rvga_word mem_r [DEPTH];
  rvga_word rdata_r;
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] cnt_r;

  assign idx = addr_i[2 +: IDX_W]; // Wraps at the memory depth.

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_r[i] <= '0;
      end
    end else if (w_v_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem_r[idx][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
  end

  // Read data is taken at the request and held until the response.
  always_ff @(posedge clk_i) begin
    if (r_v_i) begin
      rdata_r <= mem_r[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_r <= '0;
    end else if (r_v_i | w_v_i) begin
      cnt_r <= CNT_W'(LAT);
    end else if (cnt_r != '0) begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  assign resp_v_o = (cnt_r == CNT_W'(1));
  assign data_o   = rdata_r;

endmodule : data_ram

// File: source/rvga_mem_top.sv
module rvga_mem_top import rvga_types::*;
  (input logic clk_i
   , input logic rst_n_i

   , input logic stall_v_i
   , input logic flush_v_i

   , input rvga_execute_cword cword_i
   , output rvga_memory_cword cword_o

   , output logic br_v_o
   , output logic mem_stall_o
   );

  logic dmem_r_v;
  logic dmem_w_v;
  logic dmem_resp_v;
  logic [3:0] dmem_be;
  rvga_word dmem_addr;
  rvga_word dmem_wdata;
  rvga_word dmem_rdata;

  memory_stage u_stage
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.stall_v_i(stall_v_i)
     ,.flush_v_i(flush_v_i)
     ,.cword_i(cword_i)
     ,.cword_o(cword_o)
     ,.dmem_r_v_o(dmem_r_v)
     ,.dmem_w_v_o(dmem_w_v)
     ,.dmem_addr_o(dmem_addr)
     ,.dmem_data_o(dmem_wdata)
     ,.dmem_be_o(dmem_be)
     ,.dmem_data_i(dmem_rdata)
     ,.dmem_resp_v_i(dmem_resp_v)
     ,.mem_stall_o(mem_stall_o)
     ,.br_v_o(br_v_o)
     );

  data_ram u_ram
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.r_v_i(dmem_r_v)
     ,.w_v_i(dmem_w_v)
     ,.addr_i(dmem_addr)
     ,.data_i(dmem_wdata)
     ,.be_i(dmem_be)
     ,.data_o(dmem_rdata)
     ,.resp_v_o(dmem_resp_v)
     );

endmodule : rvga_mem_top

// File: bench/rvga_mem_properties.sv
module rvga_mem_properties
  (input logic clk_i
   , input logic rst_n_i
   , input logic r_v_i
   , input logic w_v_i
   , input logic resp_v_i
   , input logic stall_i
   );

  int unsigned fail_cnt = 0; // Assertion failures so far.

  req_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_v_i | w_v_i) |=> !(r_v_i | w_v_i))
    else begin
      $error("memory request longer than one cycle");
      fail_cnt++;
    end

  req_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(r_v_i & w_v_i))
    else begin
      $error("read and write requested together");
      fail_cnt++;
    end

  // Only one access is outstanding.
  no_req_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |-> !(r_v_i | w_v_i))
    else begin
      $error("request issued while the stage is stalled");
      fail_cnt++;
    end

  stall_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_v_i | w_v_i) |=> stall_i)
    else begin
      $error("stall did not rise after a request");
      fail_cnt++;
    end

  stall_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !stall_i)
    else begin
      $error("stall high after reset");
      fail_cnt++;
    end

  stall_falls_on_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stall_i & resp_v_i) |=> !stall_i)
    else begin
      $error("stall did not fall after the response");
      fail_cnt++;
    end

  stall_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (stall_i & !resp_v_i) |=> stall_i)
    else begin
      $error("stall fell before the response");
      fail_cnt++;
    end

endmodule : rvga_mem_properties

bind memory_stage rvga_mem_properties u_props
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.r_v_i(dmem_r_v_o)
   ,.w_v_i(dmem_w_v_o)
   ,.resp_v_i(dmem_resp_v_i)
   ,.stall_i(mem_stall_o)
   );

// File: bench/rvga_mem_tb.sv
`include "rvga_defs.svh"

module rvga_mem_tb import rvga_types::*; ();

  localparam int unsigned MEM_BYTES = 4 * `RVGA_DMEM_WORDS;
  localparam int unsigned WAIT_MAX  = 20 * (`RVGA_DMEM_LAT + 1);

  logic clk;
  logic rst_n;
  logic stall_v;
  logic flush_v;
  logic br_v;
  logic mem_stall;
  rvga_execute_cword cword_in;
  rvga_memory_cword cword_out;

  logic [7:0] model_mem [MEM_BYTES]; // Mirror of data_ram, byte addressed.
  rvga_memory_cword exp_q [$];
  rvga_mem_f3_e widths [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
  rvga_opcode_e alu_ops [6] = '{OP_OP, OP_OPIMM, OP_LUI, OP_JAL, OP_BRANCH, OP_NOP};
  string test_name;
  int checks;
  int errors;
  int test_errors;

  rvga_mem_top u_rvga_mem_top
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.stall_v_i(stall_v)
     ,.flush_v_i(flush_v)
     ,.cword_i(cword_in)
     ,.cword_o(cword_out)
     ,.br_v_o(br_v)
     ,.mem_stall_o(mem_stall)
     );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_cword(input string what, input rvga_memory_cword exp,
                             input rvga_memory_cword act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input rvga_word exp, input rvga_word act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  task automatic test_begin(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic test_end();
    $display("test %s: %0d errors", test_name, errors - test_errors);
  endtask

  function automatic rvga_execute_cword rand_fields();
    logic [$bits(rvga_execute_cword)+31:0] bits;
    for (int i = 0; i < $bits(rvga_execute_cword); i += 32) begin
      bits[i +: 32] = $urandom;
    end
    return rvga_execute_cword'(bits[$bits(rvga_execute_cword)-1:0]);
  endfunction

  function automatic rvga_execute_cword alu_word();
    rvga_execute_cword w;
    w = rand_fields();
    w.opcode = alu_ops[$urandom_range(0, 5)];
    return w;
  endfunction

  function automatic rvga_execute_cword mem_word(input rvga_opcode_e op,
                                                input rvga_mem_f3_e f3, input rvga_word addr);
    rvga_execute_cword w;
    w = rand_fields();
    w.opcode     = op;
    w.funct3     = f3;
    w.alu_result = addr;
    return w;
  endfunction

  // Byte offset inside a word, aligned or not for the width.
  function automatic int unsigned pick_off(input rvga_mem_f3_e f3, input bit aligned);
    case (f3)
      F3_W: return aligned ? 0 : $urandom_range(1, 3);
      F3_H, F3_HU: return 2 * $urandom_range(0, 1) + (aligned ? 0 : 1);
      default: return $urandom_range(0, 3);
    endcase
  endfunction

  function automatic rvga_execute_cword rand_op();
    int unsigned kind;
    rvga_mem_f3_e f3;
    rvga_word addr;
    kind = $urandom_range(0, 3);
    if (kind < 2) begin
      return alu_word();
    end
    f3   = widths[$urandom_range(0, (kind == 2) ? 4 : 2)]; // Stores use B, H, W.
    addr = 4 * $urandom_range(0, 63) + pick_off(f3, $urandom_range(0, 3) != 0);
    return mem_word((kind == 2) ? OP_LOAD : OP_STORE, f3, addr);
  endfunction

  // Expected memory word, also updates the memory mirror for stores.
  task automatic predict(input rvga_execute_cword w, input bit kill, input bit late_flush,
                         output rvga_memory_cword e, output bit mem_v);
    rvga_mem_f3_e f3;
    int unsigned a;
    int unsigned n;
    logic misalign;
    rvga_word v;
    f3 = rvga_mem_f3_e'(w.funct3);
    a  = w.alu_result % MEM_BYTES;
    n  = (f3 == F3_W) ? 4 : ((f3 == F3_H) || (f3 == F3_HU)) ? 2 : 1;
    misalign = ((w.opcode == OP_LOAD) || (w.opcode == OP_STORE)) && (a % n != 0);
    mem_v = !kill && !misalign && ((w.opcode == OP_LOAD) || (w.opcode == OP_STORE));
    v = w.alu_result;
    if (mem_v && (w.opcode == OP_STORE)) begin
      for (int i = 0; i < n; i++) begin
        model_mem[a + i] = w.rs2_data[8*i +: 8];
      end
    end
    if (mem_v && (w.opcode == OP_LOAD)) begin
      v = '0;
      for (int i = 0; i < n; i++) begin
        v[8*i +: 8] = model_mem[a + i];
      end
      if ((f3 == F3_B) && v[7]) v[31:8] = '1;
      if ((f3 == F3_H) && v[15]) v[31:16] = '1;
    end
    if (kill || (late_flush && mem_v)) begin
      e = '0;
    end else begin
      e = rvga_memory_cword'({w, v, misalign});
    end
  endtask

  // Offers one word, optionally stalled first, and checks its result.
  task automatic run_op(input rvga_execute_cword w, input int stalls, input bit kill,
                        input bit late_flush);
    rvga_memory_cword held;
    rvga_memory_cword e;
    bit mem_v;
    int lat;
    held     = cword_out;
    cword_in = w;
    for (int i = 0; i < stalls; i++) begin
      stall_v = 1'b1;
      @(posedge clk);
      #1;
      check_cword("hold", held, cword_out);
      if (mem_stall) report_fault("memory request issued while stalled");
    end
    stall_v = 1'b0;
    flush_v = kill;
    predict(w, kill, late_flush, e, mem_v);
    exp_q.push_back(e);
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      lat++;
      flush_v = late_flush & mem_stall & (lat == 1); // One flush pulse as the wait starts.
    end while (mem_stall && (lat < WAIT_MAX));
    if (mem_stall) report_fault("timeout, mem_stall_o never fell");
    check_word("latency", mem_v ? `RVGA_DMEM_LAT + 1 : 1, lat);
    e = exp_q.pop_front();
    check_cword("cword", e, cword_out);
    check_bit("br_v", e.br_v, br_v);
  endtask

  initial begin
    int seed_ret;
    rvga_word a;
    rvga_mem_f3_e f;
    rvga_execute_cword w;
    seed_ret = $urandom(32'h1ebcd07e);
    rst_n    = 1'b0;
    stall_v  = 1'b0;
    flush_v  = 1'b0;
    cword_in = '0;
    checks   = 0;
    errors   = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_begin("reset");
    check_cword("cword", '0, cword_out);
    check_bit("mem_stall", 1'b0, mem_stall);
    check_bit("br_v", 1'b0, br_v);
    repeat (4) run_op(mem_word(OP_LOAD, F3_W, 4 * $urandom_range(0, 63)), 0, 1'b0, 1'b0);
    test_end();

    test_begin("alu_pass");
    repeat (30) run_op(alu_word(), 0, 1'b0, 1'b0);
    test_end();

    test_begin("store_load");
    for (int i = 0; i < 40; i++) begin
      a = 4 * $urandom_range(0, 15);
      run_op(mem_word(OP_STORE, F3_W, a), 0, 1'b0, 1'b0);
      f = widths[i % 2];
      run_op(mem_word(OP_STORE, f, a + pick_off(f, 1'b1)), 0, 1'b0, 1'b0);
      f = widths[i % 5];
      run_op(mem_word(OP_LOAD, f, a + pick_off(f, 1'b1)), 0, 1'b0, 1'b0);
      run_op(mem_word(OP_LOAD, F3_W, a), 0, 1'b0, 1'b0); // Untouched bytes.
    end
    test_end();

    test_begin("latency");
    for (int i = 0; i < 10; i++) begin
      run_op(mem_word(OP_STORE, widths[i % 3], 4 * $urandom_range(0, 63)), 0, 1'b0, 1'b0);
      run_op(mem_word(OP_LOAD, widths[i % 5], 4 * $urandom_range(0, 63)), 0, 1'b0, 1'b0);
    end
    test_end();

    test_begin("misalign");
    for (int i = 0; i < 10; i++) begin
      a = 4 * $urandom_range(0, 63);
      f = (i % 2) ? F3_H : F3_W;
      run_op(mem_word(OP_STORE, f, a + pick_off(f, 1'b0)), 0, 1'b0, 1'b0);
      run_op(mem_word(OP_LOAD, f, a + pick_off(f, 1'b0)), 0, 1'b0, 1'b0);
      run_op(mem_word(OP_LOAD, F3_W, a), 0, 1'b0, 1'b0);
    end
    test_end();

    test_begin("flush");
    for (int i = 0; i < 8; i++) begin
      w = alu_word();
      w.br_v = 1'b1;
      run_op(w, 0, 1'b0, 1'b0);
      run_op(alu_word(), 0, 1'b1, 1'b0);
      a = 4 * $urandom_range(0, 63);
      run_op(mem_word(OP_STORE, F3_W, a), 0, 1'b1, 1'b0); // Killed before the request.
      run_op(mem_word(OP_LOAD, F3_W, a), 0, 1'b0, 1'b1);
      run_op(mem_word(OP_LOAD, F3_W, a), 0, 1'b0, 1'b0);
    end
    test_end();

    test_begin("stall");
    repeat (20) run_op(rand_op(), $urandom_range(1, 4), 1'b0, 1'b0);
    test_end();

    test_begin("random");
    for (int i = 0; i < 300; i++) begin
      w = rand_op();
      run_op(w, ($urandom_range(0, 7) == 0) ? $urandom_range(1, 3) : 0,
             $urandom_range(0, 19) == 0, (w.opcode == OP_LOAD) && ($urandom_range(0, 9) == 0));
    end
    test_end();

    if (u_rvga_mem_top.u_stage.u_props.fail_cnt != 0) begin
      report_fault("protocol assertions failed in the memory stage");
    end
    $display("totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : rvga_mem_tb

// File: rvga_mem.f
+incdir+source
source/rvga_pkg.sv
source/memory_ctl.sv
source/memory_dp.sv
source/memory_stage.sv
source/data_ram.sv
source/rvga_mem_top.sv
bench/rvga_mem_properties.sv
bench/rvga_mem_tb.sv

// File: Bender.yml
package:
  name: rvga_mem

sources:
  - include_dirs:
      - source
    files:
      - source/rvga_pkg.sv
      - source/memory_ctl.sv
      - source/memory_dp.sv
      - source/memory_stage.sv
      - source/data_ram.sv
      - source/rvga_mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/rvga_mem_properties.sv
      - bench/rvga_mem_tb.sv
